// ==== hw/rs_pkg.sv ====
package rs_pkg;

    localparam int WAYS     = 3;    // Dispatch and issue width
    localparam int TAG_BITS = 6;
    localparam int FU_COUNT = 8;

    typedef logic [TAG_BITS-1:0] tag_t;

    typedef enum logic [1:0] {alu, ls, mult, branch} fu_class_t;

    typedef enum logic [2:0] {
        alu_1, alu_2, alu_3, ls_1, ls_2, mult_1, mult_2, branch_1
    } fu_unit_t;

    // Bit n of the vector is unit n of fu_unit_t
    typedef struct packed {
        logic branch_1;
        logic mult_2;
        logic mult_1;
        logic ls_2;
        logic ls_1;
        logic alu_3;
        logic alu_2;
        logic alu_1;
    } fu_state_t;

    typedef struct packed {
        logic      valid;
        fu_class_t fu_class;
        logic [3:0] op;
        tag_t      dest;
        tag_t      src1;
        logic      src1_ready;
        tag_t      src2;
        logic      src2_ready;
    } rs_packet_t;

    typedef struct packed {
        logic       valid;
        fu_unit_t   fu_unit;
        logic [3:0] op;
        tag_t       dest;
        tag_t       src1;
        tag_t       src2;
    } issue_packet_t;

    typedef struct packed {
        tag_t t2;
        tag_t t1;
        tag_t t0;
    } cdb_t;

    // Tag 0 is never broadcast
    function automatic logic cdb_hit(tag_t tag, cdb_t cdb);
        return (tag != '0) && (tag == cdb.t0 || tag == cdb.t1 || tag == cdb.t2);
    endfunction

    // Concrete units that can serve a class
    function automatic logic [FU_COUNT-1:0] class_units(fu_class_t fu_class);
        case (fu_class)
            alu:     return 8'b0000_0111;
            ls:      return 8'b0001_1000;
            mult:    return 8'b0110_0000;
            default: return 8'b1000_0000;
        endcase
    endfunction

endpackage

// ==== hw/rs_if.sv ====
// Allocation path between dispatch and the entry array
interface rs_alloc_if import rs_pkg::*; #(
    parameter int RS_SIZE = 16
);
    logic [WAYS-1:0][RS_SIZE-1:0] grant;    // One-hot per slot, or zero
    rs_packet_t [WAYS-1:0]        packet;   // Incoming packets after wakeup
    logic [RS_SIZE-1:0]           free;

    modport alloc (
        output grant,
        output packet,
        input  free
    );

    modport array (
        input  grant,
        input  packet,
        output free
    );
endinterface

interface rs_wake_if import rs_pkg::*; #(
    parameter int RS_SIZE = 16
);
    rs_packet_t [RS_SIZE-1:0] entries;
    logic [RS_SIZE-1:0]       issued;

    modport array (
        output entries,
        input  issued
    );

    modport select (
        input  entries,
        output issued
    );
endinterface

// ==== hw/rs_dispatch.sv ====
module rs_dispatch import rs_pkg::*; #(
    parameter int RS_SIZE = 16
) (
    input  rs_packet_t [WAYS-1:0] dispatch,
    input  cdb_t                  cdb,
    rs_alloc_if.alloc             alloc,
    output logic [WAYS-1:0]       struct_stall
);

    logic [RS_SIZE-1:0] remaining;    // Free entries not yet granted

    function automatic logic [RS_SIZE-1:0] lowest_one(input logic [RS_SIZE-1:0] req);
        return req & (~req + 1'b1);
    endfunction

    // Slot 2 is served first, each slot takes the lowest free entry left
    always_comb begin
        remaining = alloc.free;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (dispatch[w].valid) begin
                alloc.grant[w]  = lowest_one(remaining);
                struct_stall[w] = (remaining == '0);
            end else begin
                alloc.grant[w]  = '0;
                struct_stall[w] = 1'b0;
            end
            remaining = remaining & ~alloc.grant[w];
        end
    end

    // A result broadcast this cycle also wakes the instruction being dispatched
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            alloc.packet[w] = dispatch[w];
            alloc.packet[w].src1_ready = dispatch[w].src1_ready | cdb_hit(dispatch[w].src1, cdb);
            alloc.packet[w].src2_ready = dispatch[w].src2_ready | cdb_hit(dispatch[w].src2, cdb);
        end
    end

endmodule

// ==== hw/rs_entry_array.sv ====
module rs_entry_array import rs_pkg::*; #(
    parameter int RS_SIZE = 16
) (
    input  logic      clock,
    input  logic      reset,
    input  cdb_t      cdb,
    rs_alloc_if.array alloc,
    rs_wake_if.array  wake
);

    rs_packet_t [RS_SIZE-1:0] entries;
    rs_packet_t [RS_SIZE-1:0] entries_next;
    logic [RS_SIZE-1:0]       granted;

    assign wake.entries = entries;

    // An entry issuing this cycle may be refilled at the same edge
    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            alloc.free[i] = !entries[i].valid || wake.issued[i];
        end
    end

    always_comb begin
        granted = '0;
        for (int i = 0; i < RS_SIZE; i++) begin
            entries_next[i] = entries[i];
            if (wake.issued[i]) begin
                entries_next[i].valid = 1'b0;
            end else begin
                entries_next[i].src1_ready = entries[i].src1_ready | cdb_hit(entries[i].src1, cdb);
                entries_next[i].src2_ready = entries[i].src2_ready | cdb_hit(entries[i].src2, cdb);
            end
            for (int w = 0; w < WAYS; w++) begin
                if (alloc.grant[w][i]) begin
                    entries_next[i] = alloc.packet[w];
                    granted[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < RS_SIZE; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            entries <= entries_next;
        end
    end

    // Grants come from rs_dispatch and must only land on free entries
    a_grant_free: assert property (@(posedge clock) disable iff (reset)
        (granted & ~alloc.free) == '0);

    for (genvar a = 0; a < WAYS; a++) begin : g_grant_chk
        a_grant_onehot: assert property (@(posedge clock) disable iff (reset)
            $onehot0(alloc.grant[a]));
        for (genvar b = a + 1; b < WAYS; b++) begin : g_pair
            a_grant_disjoint: assert property (@(posedge clock) disable iff (reset)
                (alloc.grant[a] & alloc.grant[b]) == '0);
        end
    end

endmodule

// ==== hw/rs_issue_select.sv ====
module rs_issue_select import rs_pkg::*; #(
    parameter int RS_SIZE = 16
) (
    input  fu_state_t                fu_ready,
    rs_wake_if.select                wake,
    output issue_packet_t [WAYS-1:0] issue
);

    logic [RS_SIZE-1:0]  operands_ready;
    logic [RS_SIZE-1:0]  picked;
    logic [FU_COUNT-1:0] units_left;      // Free units not yet bound by an earlier pass

    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            operands_ready[i] = wake.entries[i].valid &&
                                wake.entries[i].src1_ready &&
                                wake.entries[i].src2_ready;
        end
    end

    // Three chained passes. Units only disappear from pass to pass, so the
    // picked entries come out in ascending index order
    always_comb begin
        logic                found;
        int                  sel;
        logic [FU_COUNT-1:0] class_free;
        logic [FU_COUNT-1:0] unit_mask;

        units_left = fu_ready;
        picked     = '0;
        for (int p = 0; p < WAYS; p++) begin
            found      = 1'b0;
            sel        = 0;
            class_free = '0;
            unit_mask  = '0;
            issue[p]   = '0;

            for (int i = 0; i < RS_SIZE; i++) begin
                if (!found && operands_ready[i] && !picked[i] &&
                    (units_left & class_units(wake.entries[i].fu_class)) != '0) begin
                    found = 1'b1;
                    sel   = i;
                end
            end

            if (found) begin
                class_free = units_left & class_units(wake.entries[sel].fu_class);
                unit_mask  = class_free & (~class_free + 1'b1);    // Lowest unit of the class
                units_left = units_left & ~unit_mask;
                picked[sel] = 1'b1;

                issue[p].valid = 1'b1;
                issue[p].op    = wake.entries[sel].op;
                issue[p].dest  = wake.entries[sel].dest;
                issue[p].src1  = wake.entries[sel].src1;
                issue[p].src2  = wake.entries[sel].src2;
                for (int u = 0; u < FU_COUNT; u++) begin
                    if (unit_mask[u]) begin
                        issue[p].fu_unit = fu_unit_t'(u[2:0]);
                    end
                end
            end
        end
    end

    assign wake.issued = picked;

endmodule

// ==== hw/rs_top.sv ====
module rs_top import rs_pkg::*; #(
    parameter int RS_SIZE = 16
) (
    input  logic                     clock,
    input  logic                     reset,
    input  rs_packet_t [WAYS-1:0]    dispatch,
    input  cdb_t                     cdb,
    input  fu_state_t                fu_ready,
    output logic [WAYS-1:0]          struct_stall,
    output issue_packet_t [WAYS-1:0] issue
);

    rs_alloc_if #(.RS_SIZE(RS_SIZE)) alloc_if ();
    rs_wake_if  #(.RS_SIZE(RS_SIZE)) wake_if ();

    rs_dispatch #(.RS_SIZE(RS_SIZE)) u_dispatch (
        .dispatch     (dispatch),
        .cdb          (cdb),
        .alloc        (alloc_if.alloc),
        .struct_stall (struct_stall)
    );

    rs_entry_array #(.RS_SIZE(RS_SIZE)) u_entry_array (
        .clock (clock),
        .reset (reset),
        .cdb   (cdb),
        .alloc (alloc_if.array),
        .wake  (wake_if.array)
    );

    rs_issue_select #(.RS_SIZE(RS_SIZE)) u_issue_select (
        .fu_ready (fu_ready),
        .wake     (wake_if.select),
        .issue    (issue)
    );

    // Binding across the issue slots against the unit levels from outside
    for (genvar a = 0; a < WAYS; a++) begin : g_issue_chk
        a_unit_ready: assert property (@(posedge clock) disable iff (reset)
            issue[a].valid |-> fu_ready[issue[a].fu_unit]);
        for (genvar b = a + 1; b < WAYS; b++) begin : g_pair
            a_unit_unique: assert property (@(posedge clock) disable iff (reset)
                !(issue[a].valid && issue[b].valid && issue[a].fu_unit == issue[b].fu_unit));
        end
    end

endmodule

// ==== testbench/tb_clock.sv ====
module tb_clock (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;    // Period 20
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

// ==== testbench/rs_checker.sv ====
module rs_checker import rs_pkg::*; #(
    parameter int RS_SIZE = 16
) (
    input  logic                     clock,
    input  logic                     reset,
    input  rs_packet_t [WAYS-1:0]    dispatch,
    input  cdb_t                     cdb,
    input  fu_state_t                fu_ready,
    input  logic [WAYS-1:0]          struct_stall,
    input  issue_packet_t [WAYS-1:0] issue,
    output int                       errors,
    output int                       checks
);

    rs_packet_t model [RS_SIZE];    // Registered station contents as seen after the next edge

    function automatic logic on_cdb(tag_t tag, cdb_t bus);
        logic hit;
        hit = 1'b0;
        for (int l = 0; l < WAYS; l++) begin
            if (tag != '0 && bus[l*TAG_BITS +: TAG_BITS] == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic fu_class_t unit_class(int u);
        if (u < 3) return alu;
        if (u < 5) return ls;
        if (u < 7) return mult;
        return branch;
    endfunction

    // Outputs are stable at the falling edge, inputs change only at the rising edge
    always @(negedge clock) begin
        logic [FU_COUNT-1:0]      units;
        logic [RS_SIZE-1:0]       issuing;
        issue_packet_t [WAYS-1:0] expected;
        rs_packet_t               pkt;
        logic                     stall_exp;
        int                       n;
        int                       u;
        int                       slot;

        if (reset) begin
            for (int i = 0; i < RS_SIZE; i++) begin
                model[i] = '0;
            end
            errors = 0;
            checks = 0;
        end else begin
            units    = fu_ready;
            issuing  = '0;
            expected = '0;
            n        = 0;
            // Ascending scan; an entry skipped for lack of a unit stays skipped
            for (int i = 0; i < RS_SIZE; i++) begin
                if (n < WAYS && model[i].valid && model[i].src1_ready && model[i].src2_ready) begin
                    u = -1;
                    for (int k = 0; k < FU_COUNT; k++) begin
                        if (u < 0 && units[k] && unit_class(k) == model[i].fu_class) begin
                            u = k;
                        end
                    end
                    if (u >= 0) begin
                        units[u]            = 1'b0;
                        issuing[i]          = 1'b1;
                        expected[n].valid   = 1'b1;
                        expected[n].fu_unit = fu_unit_t'(u[2:0]);
                        expected[n].op      = model[i].op;
                        expected[n].dest    = model[i].dest;
                        expected[n].src1    = model[i].src1;
                        expected[n].src2    = model[i].src2;
                        n++;
                    end
                end
            end

            for (int p = 0; p < WAYS; p++) begin
                checks++;
                if (issue[p] !== expected[p]) begin
                    errors++;
                    $display("ERROR at %0t: issue slot %0d is %h, expected %h",
                             $time, p, issue[p], expected[p]);
                end
            end

            for (int i = 0; i < RS_SIZE; i++) begin
                if (issuing[i]) begin
                    model[i].valid = 1'b0;
                end else begin
                    model[i].src1_ready = model[i].src1_ready | on_cdb(model[i].src1, cdb);
                    model[i].src2_ready = model[i].src2_ready | on_cdb(model[i].src2, cdb);
                end
            end

            // Slot 2 first, each valid slot takes the lowest free entry
            for (int w = WAYS - 1; w >= 0; w--) begin
                slot = -1;
                if (dispatch[w].valid) begin
                    for (int i = 0; i < RS_SIZE; i++) begin
                        if (slot < 0 && !model[i].valid) begin
                            slot = i;
                        end
                    end
                end
                stall_exp = dispatch[w].valid && slot < 0;
                checks++;
                if (struct_stall[w] !== stall_exp) begin
                    errors++;
                    $display("ERROR at %0t: struct_stall[%0d] is %b, expected %b",
                             $time, w, struct_stall[w], stall_exp);
                end
                if (slot >= 0) begin
                    pkt            = dispatch[w];
                    pkt.src1_ready = pkt.src1_ready | on_cdb(pkt.src1, cdb);
                    pkt.src2_ready = pkt.src2_ready | on_cdb(pkt.src2, cdb);
                    model[slot]    = pkt;
                end
            end
        end
    end

endmodule

// ==== testbench/tb_rs.sv ====
module tb_rs import rs_pkg::*; ();

    localparam int RS_SIZE = 16;
    localparam int CYCLES  = 2000;

    logic                     clock;
    logic                     reset;
    rs_packet_t [WAYS-1:0]    dispatch;
    cdb_t                     cdb;
    fu_state_t                fu_ready;
    logic [WAYS-1:0]          struct_stall;
    issue_packet_t [WAYS-1:0] issue;
    int                       errors;
    int                       checks;

    integer          seed = 25715;
    logic [WAYS-1:0] held;        // Slots stalled last cycle and held upstream
    logic [63:0]     busy;        // Tags owned by an instruction in flight
    tag_t            next_tag;
    tag_t            pending[$];  // Accepted destinations not yet broadcast
    tag_t            to_send[$];  // Issued destinations waiting for the CDB

    tb_clock clock_gen (
        .clock (clock),
        .reset (reset)
    );

    rs_top #(.RS_SIZE(RS_SIZE)) UUT (
        .clock        (clock),
        .reset        (reset),
        .dispatch     (dispatch),
        .cdb          (cdb),
        .fu_ready     (fu_ready),
        .struct_stall (struct_stall),
        .issue        (issue)
    );

    rs_checker #(.RS_SIZE(RS_SIZE)) scoreboard (
        .clock        (clock),
        .reset        (reset),
        .dispatch     (dispatch),
        .cdb          (cdb),
        .fu_ready     (fu_ready),
        .struct_stall (struct_stall),
        .issue        (issue),
        .errors       (errors),
        .checks       (checks)
    );

    function automatic int find_pending(tag_t tag);
        int idx;
        idx = -1;
        foreach (pending[i]) begin
            if (pending[i] == tag) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic send_broadcasts();
        tag_t [WAYS-1:0] lanes;
        int              idx;
        lanes = '0;
        for (int l = 0; l < WAYS; l++) begin
            if (to_send.size() > 0 && $unsigned($random(seed)) % 4 != 0) begin
                idx      = $unsigned($random(seed)) % to_send.size();
                lanes[l] = to_send[idx];
                to_send.delete(idx);
                idx = find_pending(lanes[l]);
                if (idx >= 0) begin
                    pending.delete(idx);
                end
                busy[lanes[l]] = 1'b0;
            end
        end
        cdb <= lanes;
    endtask

    task automatic make_source(output tag_t tag, output logic ready);
        if (pending.size() > 0 && $unsigned($random(seed)) % 3 != 0) begin
            tag   = pending[$unsigned($random(seed)) % pending.size()];
            ready = 1'b0;
        end else begin
            tag   = '0;    // No register needed
            ready = 1'b1;
        end
    endtask

    task automatic make_packet(output rs_packet_t pkt);
        pkt       = '0;
        pkt.valid = ($unsigned($random(seed)) % 3) != 0;
        if (pkt.valid) begin
            pkt.fu_class = fu_class_t'($random(seed) & 3);
            pkt.op       = $random(seed) & 15;
            make_source(pkt.src1, pkt.src1_ready);
            make_source(pkt.src2, pkt.src2_ready);
            for (int k = 0; k < 63 && busy[next_tag]; k++) begin
                next_tag = (next_tag == 6'd63) ? 6'd1 : next_tag + 6'd1;
            end
            pkt.dest       = next_tag;
            busy[next_tag] = 1'b1;
            next_tag = (next_tag == 6'd63) ? 6'd1 : next_tag + 6'd1;
        end
    endtask

    task automatic drive_cycle();
        rs_packet_t [WAYS-1:0] pkts;
        pkts = '0;
        // Only broadcasts of earlier cycles; one on the CDB now is left to the DUT
        for (int w = 0; w < WAYS; w++) begin
            if (held[w]) begin
                pkts[w] = dispatch[w];
                if (find_pending(pkts[w].src1) < 0) pkts[w].src1_ready = 1'b1;
                if (find_pending(pkts[w].src2) < 0) pkts[w].src2_ready = 1'b1;
            end
        end
        send_broadcasts();
        for (int w = 0; w < WAYS; w++) begin
            if (!held[w]) begin
                make_packet(pkts[w]);
            end
            dispatch[w] <= pkts[w];
        end
        fu_ready <= fu_state_t'($random(seed) | $random(seed));
    endtask

    always @(negedge clock) begin
        held = '0;
        if (!reset) begin
            for (int w = 0; w < WAYS; w++) begin
                if (dispatch[w].valid && struct_stall[w]) begin
                    held[w] = 1'b1;
                end else if (dispatch[w].valid) begin
                    pending.push_back(dispatch[w].dest);
                end
            end
            for (int p = 0; p < WAYS; p++) begin
                if (issue[p].valid) begin
                    to_send.push_back(issue[p].dest);
                end
            end
        end
    end

    initial begin
        int wait_cycles;
        dispatch    = '0;
        cdb         = '0;
        fu_ready    = '0;
        held        = '0;
        busy        = '0;
        next_tag    = 6'd1;
        wait_cycles = 0;
        while (reset !== 1'b0 && wait_cycles < 100) begin
            @(posedge clock);
            wait_cycles++;
        end
        if (reset !== 1'b0) begin
            $display("Reset was never released, giving up");
            $display("RESULT: FAIL");
            $finish;
        end else begin
            for (int cyc = 0; cyc < CYCLES; cyc++) begin
                drive_cycle();
                @(posedge clock);
            end
            $display("Checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

// ==== rs_issue.f ====
hw/rs_pkg.sv
hw/rs_if.sv
hw/rs_dispatch.sv
hw/rs_entry_array.sv
hw/rs_issue_select.sv
hw/rs_top.sv
testbench/tb_clock.sv
testbench/rs_checker.sv
testbench/tb_rs.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compiles the reservation station with its testbench and runs it under Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_rs \
    -f rs_issue.f -o sim_rs
./obj_dir/sim_rs > sim.log
cat sim.log

if grep -qx "RESULT: PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
